// ==== src.f ====
exec_pkg.sv
reg_file.sv
operand_stage.sv
alu.sv
mult_unit.sv
writeback_stage.sv
exec_backend.sv
tb_exec_backend.sv

// ==== Makefile ====
TOP       ?= tb_exec_backend
VERILATOR ?= verilator
LOG       ?= sim.log
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_exec_backend.sv ====
`timescale 1ns/1ps

module tb_exec_backend;

	localparam int MULT_CYCLES = 3;
	localparam int WAIT_LIMIT = 50;

	typedef struct {
		int              due;
		exec_pkg::done_t rpt;
	} expect_t;

	logic               clk;
	logic               rst;
	exec_pkg::iss_pkt_t iss  [exec_pkg::NUM_FU];
	logic               mult_free;
	exec_pkg::done_t    done [exec_pkg::NUM_FU];

	exec_pkg::data_t             shadow  [exec_pkg::NUM_PREG];
	expect_t                     exp_q   [exec_pkg::NUM_FU][$];
	exec_pkg::done_t             exp_rpt [exec_pkg::NUM_FU];
	logic [exec_pkg::NUM_FU-1:0] exp_vld = '0;
	logic                        exp_free = 1'b1;
	int                          cyc = 0;
	int                          free_lo = -1;
	int                          free_hi = -1;
	int                          rpt_err [exec_pkg::NUM_FU] = '{default: 0};
	int                          free_err = 0;
	int                          timeouts = 0;
	int                          errs_seen = 0;
	int                          tests_failed = 0;
	logic [31:0]                 rng = 32'd57588;
	exec_pkg::rob_idx_t          rob_n = '0;

	exec_backend #(
		.MULT_CYCLES (MULT_CYCLES)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.iss       (iss),
		.mult_free (mult_free),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			if (exp_vld[u]) begin
				void'(exp_q[u].pop_front());
			end
		end
	end

	// expected outputs for the coming edge
	always @(negedge clk) begin
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			exp_vld[u] = 1'b0;
			if (exp_q[u].size() != 0) begin
				exp_vld[u] = (exp_q[u][0].due == cyc);
				exp_rpt[u] = exp_q[u][0].rpt;
			end
		end
		exp_free = !(cyc >= free_lo && cyc <= free_hi);
	end

	for (genvar u = 0; u < exec_pkg::NUM_FU; u++) begin : g_chk
		a_rpt_value : assert property (@(posedge clk) disable iff (rst)
			(exp_vld[u] && done[u].valid) |-> (done[u] == exp_rpt[u])
		) else begin
			rpt_err[u]++;
			$display("** Error at %0t: unit %0d gave rob %0d dst %0d data %h, expected %0d %0d %h",
				$time, u, $sampled(done[u].rob), $sampled(done[u].dst),
				$sampled(done[u].data), exp_rpt[u].rob, exp_rpt[u].dst, exp_rpt[u].data);
		end
		a_rpt_missing : assert property (@(posedge clk) disable iff (rst)
			exp_vld[u] |-> done[u].valid
		) else begin
			rpt_err[u]++;
			$display("Unit %0d never reported rob %0d at %0t.", u, exp_rpt[u].rob, $time);
		end
		a_rpt_extra : assert property (@(posedge clk) disable iff (rst)
			done[u].valid |-> exp_vld[u]
		) else begin
			rpt_err[u]++;
			$display("Unit %0d gave a report that nobody expected at %0t.", u, $time);
		end
	end

	a_free_level : assert property (@(posedge clk) disable iff (rst)
		mult_free == exp_free
	) else begin
		free_err++;
		$display("** Error at %0t: mult_free is %b, expected %b", $time, $sampled(mult_free),
			exp_free);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic exec_pkg::data_t rand16();
		rng = xorshift(rng);
		return rng[15:0];
	endfunction

	function automatic exec_pkg::preg_t pick_reg(input int lo, input int hi);
		rng = xorshift(rng);
		return exec_pkg::preg_t'(lo + (rng[15:0] % (hi - lo + 1)));
	endfunction

	function automatic exec_pkg::data_t alu_ref(input exec_pkg::data_t a,
		input exec_pkg::data_t b, input exec_pkg::data_t imm, input exec_pkg::alu_mode_t mode,
		input logic inv, input logic ldi);
		exec_pkg::data_t bb;
		bb = inv ? ~b : b;
		if (ldi) begin
			return imm;
		end
		case (mode)
			exec_pkg::ALU_ADD: return a + bb;
			exec_pkg::ALU_SUB: return a + ~bb + 16'd1;
			exec_pkg::ALU_AND: return a & bb;
			exec_pkg::ALU_OR:  return a | bb;
			exec_pkg::ALU_XOR: return a ^ bb;
			exec_pkg::ALU_SLL: return a << bb[3:0];
			exec_pkg::ALU_SRL: return a >> bb[3:0];
			default:           return bb;
		endcase
	endfunction

	function automatic exec_pkg::iss_pkt_t op_pkt(input exec_pkg::preg_t dst, input logic wrt,
		input exec_pkg::preg_t s1, input exec_pkg::preg_t s2, input exec_pkg::data_t imm,
		input logic imm_vld, input logic ldi, input logic inv, input exec_pkg::alu_mode_t mode);
		exec_pkg::iss_pkt_t p;
		p = '0;
		p.dst = dst;
		p.reg_wrt = wrt;
		p.src1 = s1;
		p.src2 = s2;
		p.imm = imm;
		p.imm_vld = imm_vld;
		p.ldi = ldi;
		p.inv_rt = inv;
		p.mode = mode;
		return p;
	endfunction

	// drive one unit and queue what it should report
	task automatic send(input int u, input exec_pkg::iss_pkt_t p);
		exec_pkg::data_t a;
		exec_pkg::data_t b;
		exec_pkg::data_t r;
		expect_t         e;
		p.valid = 1'b1;
		p.rob = rob_n;
		rob_n++;
		a = shadow[p.src1];
		b = p.imm_vld ? p.imm : shadow[p.src2];
		if (u == exec_pkg::FU_MULT) begin
			r = a * b;
		end else if (u == exec_pkg::FU_ADDR) begin
			r = a + b;
		end else begin
			r = alu_ref(a, b, p.imm, p.mode, p.inv_rt, p.ldi);
		end
		e.due = cyc + 2 + ((u == exec_pkg::FU_MULT) ? MULT_CYCLES : 0);
		e.rpt = '{valid: 1'b1, rob: p.rob, reg_wrt: p.reg_wrt, dst: p.dst, data: r};
		exp_q[u].push_back(e);
		if (p.reg_wrt) begin
			shadow[p.dst] = r;
		end
		if (u == exec_pkg::FU_MULT) begin
			free_lo = cyc + 1;
			free_hi = cyc + 1 + MULT_CYCLES;
		end
		iss[u] = p;
	endtask

	task automatic next_cycle();
		@(negedge clk);
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			iss[u].valid = 1'b0;
		end
	endtask

	task automatic wait_free();
		int n;
		n = 0;
		while (!mult_free && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!mult_free) begin
			timeouts++;
			$display("The multiplier stayed busy for %0d cycles.", WAIT_LIMIT);
		end
	endtask

	function automatic bit pending();
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			if (exp_q[u].size() != 0) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic drain();
		int n;
		n = 0;
		while (pending() && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (pending()) begin
			timeouts++;
			$display("Done reports were still outstanding after %0d cycles.", WAIT_LIMIT);
			for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
				exp_q[u].delete();
			end
		end
	endtask

	function automatic int total_errors();
		int n;
		n = free_err + timeouts;
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			n += rpt_err[u];
		end
		return n;
	endfunction

	task automatic end_test(input string name);
		int now;
		now = total_errors();
		if (now == errs_seen) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, now - errs_seen);
			tests_failed++;
		end
		errs_seen = now;
	endtask

	initial begin
		exec_pkg::preg_t d1;
		exec_pkg::preg_t d2;
		exec_pkg::preg_t n1;
		exec_pkg::preg_t n2;
		rst = 1'b1;
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			iss[u] = '0;
		end
		for (int r = 0; r < exec_pkg::NUM_PREG; r++) begin
			shadow[r] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// pass-mode reads of every register
		for (int r = 0; r < exec_pkg::NUM_PREG; r += 2) begin
			send(exec_pkg::FU_ALU1, op_pkt(exec_pkg::preg_t'(r), 1'b0, '0,
				exec_pkg::preg_t'(r), '0, 1'b0, 1'b0, 1'b0, exec_pkg::ALU_PASS));
			send(exec_pkg::FU_ALU2, op_pkt(exec_pkg::preg_t'(r + 1), 1'b0, '0,
				exec_pkg::preg_t'(r + 1), '0, 1'b0, 1'b0, 1'b0, exec_pkg::ALU_PASS));
			next_cycle();
		end
		drain();
		end_test("reset state");

		for (int i = 0; i < 8; i++) begin
			send(exec_pkg::FU_ALU1, op_pkt(exec_pkg::preg_t'(1 + i), 1'b1, '0, '0, rand16(),
				1'b1, 1'b1, 1'b0, exec_pkg::ALU_ADD));
			send(exec_pkg::FU_ALU2, op_pkt(exec_pkg::preg_t'(9 + i), 1'b1, '0, '0, rand16(),
				1'b0, 1'b1, 1'b0, exec_pkg::ALU_ADD));
			send(exec_pkg::FU_ADDR, op_pkt(exec_pkg::preg_t'(17 + i), 1'b1, '0, '0, rand16(),
				1'b1, 1'b0, 1'b0, exec_pkg::ALU_ADD));
			next_cycle();
		end
		drain();
		end_test("load immediate");

		// each op consumes the previous result two edges later
		d1 = 6'd1;
		d2 = 6'd9;
		for (int m = 0; m < 8; m++) begin
			for (int v = 0; v < 4; v++) begin
				n1 = exec_pkg::preg_t'(25 + (4 * m + v) % 16);
				n2 = exec_pkg::preg_t'(41 + (4 * m + v) % 16);
				send(exec_pkg::FU_ALU1, op_pkt(n1, 1'b1, d1, pick_reg(1, 24), rand16(),
					v[1], 1'b0, v[0], exec_pkg::alu_mode_t'(m)));
				send(exec_pkg::FU_ALU2, op_pkt(n2, 1'b1, d2, pick_reg(1, 24), rand16(),
					v[0], 1'b0, v[1], exec_pkg::alu_mode_t'(m)));
				d1 = n1;
				d2 = n2;
				next_cycle();
				next_cycle();
			end
		end
		drain();
		end_test("alu modes");

		for (int i = 0; i < 4; i++) begin
			wait_free();
			send(exec_pkg::FU_MULT, op_pkt(exec_pkg::preg_t'(57 + i), 1'b1, pick_reg(1, 24),
				pick_reg(1, 24), rand16(), i[0], 1'b0, 1'b0, exec_pkg::ALU_ADD));
			next_cycle();
		end
		drain();
		end_test("multiply");

		for (int i = 0; i < 3; i++) begin
			wait_free();
			send(exec_pkg::FU_MULT, op_pkt(6'd61, 1'b1, pick_reg(1, 24), pick_reg(1, 24), '0,
				1'b0, 1'b0, 1'b0, exec_pkg::ALU_ADD));
			send(exec_pkg::FU_ALU1, op_pkt(6'd62, 1'b1, pick_reg(1, 24), pick_reg(1, 24),
				rand16(), 1'b0, 1'b0, 1'b0, exec_pkg::ALU_XOR));
			send(exec_pkg::FU_ALU2, op_pkt(6'd63, 1'b1, pick_reg(1, 24), pick_reg(1, 24),
				rand16(), 1'b1, 1'b0, 1'b1, exec_pkg::ALU_SUB));
			send(exec_pkg::FU_ADDR, op_pkt(exec_pkg::preg_t'(25 + i), 1'b1, pick_reg(1, 24),
				'0, rand16(), 1'b1, 1'b0, 1'b0, exec_pkg::ALU_ADD));
			next_cycle();
		end
		drain();
		end_test("all units");

		// reports without register writes, then read the old values back
		wait_free();
		send(exec_pkg::FU_ALU1, op_pkt(6'd5, 1'b0, '0, '0, rand16(), 1'b1, 1'b1, 1'b0,
			exec_pkg::ALU_ADD));
		send(exec_pkg::FU_ADDR, op_pkt(6'd6, 1'b0, '0, '0, rand16(), 1'b1, 1'b0, 1'b0,
			exec_pkg::ALU_ADD));
		send(exec_pkg::FU_MULT, op_pkt(6'd7, 1'b0, pick_reg(1, 24), pick_reg(1, 24), '0,
			1'b0, 1'b0, 1'b0, exec_pkg::ALU_ADD));
		next_cycle();
		drain();
		send(exec_pkg::FU_ALU1, op_pkt(6'd5, 1'b0, '0, 6'd5, '0, 1'b0, 1'b0, 1'b0,
			exec_pkg::ALU_PASS));
		send(exec_pkg::FU_ALU2, op_pkt(6'd6, 1'b0, '0, 6'd6, '0, 1'b0, 1'b0, 1'b0,
			exec_pkg::ALU_PASS));
		send(exec_pkg::FU_ADDR, op_pkt(6'd7, 1'b0, 6'd7, '0, '0, 1'b1, 1'b0, 1'b0,
			exec_pkg::ALU_ADD));
		next_cycle();
		drain();
		end_test("no register write");

		$display("6 tests run, %0d failed, %0d errors in total", tests_failed, total_errors());
		if (total_errors() == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== exec_backend.sv ====
`timescale 1ns/1ps

module exec_backend #(
	parameter int MULT_CYCLES = 3
) (
	input  logic                clk,
	input  logic                rst,
	input  exec_pkg::iss_pkt_t  iss  [exec_pkg::NUM_FU],
	output logic                mult_free,
	output exec_pkg::done_t     done [exec_pkg::NUM_FU]
);

	exec_pkg::preg_t    rd_addr [exec_pkg::NUM_RD];
	exec_pkg::data_t    rd_data [exec_pkg::NUM_RD];
	exec_pkg::ex_pkt_t  ex      [exec_pkg::NUM_FU];
	exec_pkg::wr_port_t wr      [exec_pkg::NUM_FU];
	exec_pkg::done_t    mult_res;

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr      (wr)
	);

	// issue to rf/ex boundary
	operand_stage u_operand_stage (
		.clk     (clk),
		.rst     (rst),
		.iss     (iss),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.ex      (ex)
	);

	mult_unit #(
		.MULT_CYCLES (MULT_CYCLES)
	) u_mult_unit (
		.clk       (clk),
		.rst       (rst),
		.ex        (ex[exec_pkg::FU_MULT]),
		.mult_free (mult_free),
		.res       (mult_res)
	);

	// alus, address adder and ex/wb register
	writeback_stage u_writeback_stage (
		.clk      (clk),
		.rst      (rst),
		.ex       (ex),
		.mult_res (mult_res),
		.wr       (wr),
		.done     (done)
	);

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
	input  logic                clk,
	input  logic                rst,
	input  exec_pkg::ex_pkt_t   ex       [exec_pkg::NUM_FU],
	input  exec_pkg::done_t     mult_res,
	output exec_pkg::wr_port_t  wr       [exec_pkg::NUM_FU],
	output exec_pkg::done_t     done     [exec_pkg::NUM_FU]
);

	exec_pkg::data_t alu1_res;
	exec_pkg::data_t alu2_res;
	exec_pkg::data_t addr_res;

	alu u_alu1 (
		.op1    (ex[exec_pkg::FU_ALU1].op1),
		.op2    (ex[exec_pkg::FU_ALU1].op2),
		.imm    (ex[exec_pkg::FU_ALU1].imm),
		.mode   (ex[exec_pkg::FU_ALU1].mode),
		.inv_rt (ex[exec_pkg::FU_ALU1].inv_rt),
		.ldi    (ex[exec_pkg::FU_ALU1].ldi),
		.result (alu1_res)
	);

	alu u_alu2 (
		.op1    (ex[exec_pkg::FU_ALU2].op1),
		.op2    (ex[exec_pkg::FU_ALU2].op2),
		.imm    (ex[exec_pkg::FU_ALU2].imm),
		.mode   (ex[exec_pkg::FU_ALU2].mode),
		.inv_rt (ex[exec_pkg::FU_ALU2].inv_rt),
		.ldi    (ex[exec_pkg::FU_ALU2].ldi),
		.result (alu2_res)
	);

	// base plus offset, result goes to the rf
	assign addr_res = ex[exec_pkg::FU_ADDR].op1 + ex[exec_pkg::FU_ADDR].op2;

	for (genvar u = 0; u < exec_pkg::NUM_FU; u++) begin : g_done
		if (u == exec_pkg::FU_MULT) begin : g_mult
			// mult result is already registered in its unit
			assign done[u] = mult_res;
		end else begin : g_reg
			exec_pkg::data_t r;

			assign r = (u == exec_pkg::FU_ALU1) ? alu1_res :
				(u == exec_pkg::FU_ALU2) ? alu2_res : addr_res;

			always_ff @(posedge clk) begin
				if (rst) begin
					done[u].valid <= 1'b0;
				end else begin
					done[u].valid <= ex[u].valid;
				end
				done[u].rob     <= ex[u].rob;
				done[u].reg_wrt <= ex[u].reg_wrt;
				done[u].dst     <= ex[u].dst;
				done[u].data    <= r;
			end
		end
	end

	always_comb begin
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			wr[u].en   = done[u].valid && done[u].reg_wrt;
			wr[u].dst  = done[u].dst;
			wr[u].data = done[u].data;
		end
	end

endmodule

// ==== mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit #(
	parameter int MULT_CYCLES = 3
) (
	input  logic               clk,
	input  logic               rst,
	input  exec_pkg::ex_pkt_t  ex,
	output logic               mult_free,
	output exec_pkg::done_t    res
);

	localparam int CNT_W = (MULT_CYCLES > 1) ? $clog2(MULT_CYCLES) : 1;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DONE
	} mult_state_t;

	mult_state_t        state;
	logic [CNT_W-1:0]   cnt;
	exec_pkg::data_t    a_q;
	exec_pkg::data_t    b_q;
	exec_pkg::rob_idx_t rob_q;
	exec_pkg::preg_t    dst_q;
	logic               reg_wrt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (ex.valid) begin
						state <= BUSY;
						cnt   <= CNT_W'(MULT_CYCLES - 1);
					end
				end
				BUSY: begin
					if (cnt == '0) begin
						state <= DONE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// operands and tags
	always_ff @(posedge clk) begin
		if (state == IDLE && ex.valid) begin
			a_q       <= ex.op1;
			b_q       <= ex.op2;
			rob_q     <= ex.rob;
			dst_q     <= ex.dst;
			reg_wrt_q <= ex.reg_wrt;
		end
	end

	// also low while a fresh packet sits at the input
	assign mult_free = (state != BUSY) && !ex.valid;

	always_comb begin
		res.valid   = (state == DONE);
		res.rob     = rob_q;
		res.reg_wrt = reg_wrt_q;
		res.dst     = dst_q;
		res.data    = a_q * b_q;
	end

	// issuer must hold off until mult_free
	a_mult_idle : assert property (
		@(posedge clk) disable iff (rst) ex.valid |-> (state == IDLE)
	) else $error("multiplier packet issued while busy");

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input  exec_pkg::data_t     op1,
	input  exec_pkg::data_t     op2,
	input  exec_pkg::data_t     imm,
	input  exec_pkg::alu_mode_t mode,
	input  logic                inv_rt,
	input  logic                ldi,
	output exec_pkg::data_t     result
);

	exec_pkg::data_t b;
	exec_pkg::data_t mode_res;

	assign b = inv_rt ? ~op2 : op2;

	always_comb begin
		case (mode)
			exec_pkg::ALU_ADD:  mode_res = op1 + b;
			exec_pkg::ALU_SUB:  mode_res = op1 - b;
			exec_pkg::ALU_AND:  mode_res = op1 & b;
			exec_pkg::ALU_OR:   mode_res = op1 | b;
			exec_pkg::ALU_XOR:  mode_res = op1 ^ b;
			// shift amount from low nibble only
			exec_pkg::ALU_SLL:  mode_res = op1 << b[3:0];
			exec_pkg::ALU_SRL:  mode_res = op1 >> b[3:0];
			exec_pkg::ALU_PASS: mode_res = b;
			default:            mode_res = b;
		endcase
	end

	// load-immediate bypasses the mode result
	assign result = ldi ? imm : mode_res;

endmodule

// ==== operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
	input  logic                clk,
	input  logic                rst,
	input  exec_pkg::iss_pkt_t  iss     [exec_pkg::NUM_FU],
	output exec_pkg::preg_t     rd_addr [exec_pkg::NUM_RD],
	input  exec_pkg::data_t     rd_data [exec_pkg::NUM_RD],
	output exec_pkg::ex_pkt_t   ex      [exec_pkg::NUM_FU]
);

	exec_pkg::ex_pkt_t ex_d [exec_pkg::NUM_FU];

	// unit u reads on ports 2u and 2u+1
	always_comb begin
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			rd_addr[2*u]   = iss[u].src1;
			rd_addr[2*u+1] = iss[u].src2;
		end
	end

	always_comb begin
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			ex_d[u].valid   = iss[u].valid;
			ex_d[u].rob     = iss[u].rob;
			ex_d[u].dst     = iss[u].dst;
			ex_d[u].reg_wrt = iss[u].reg_wrt;
			ex_d[u].op1     = rd_data[2*u];
			// immediate replaces the second source
			if (iss[u].imm_vld) begin
				ex_d[u].op2 = iss[u].imm;
			end else begin
				ex_d[u].op2 = rd_data[2*u+1];
			end
			ex_d[u].imm    = iss[u].imm;
			ex_d[u].ldi    = iss[u].ldi;
			ex_d[u].inv_rt = iss[u].inv_rt;
			ex_d[u].mode   = iss[u].mode;
		end
	end

	// rf/ex pipeline register
	always_ff @(posedge clk) begin
		for (int u = 0; u < exec_pkg::NUM_FU; u++) begin
			ex[u] <= ex_d[u];
			if (rst) begin
				ex[u].valid <= 1'b0;
			end
		end
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                rst,
	input  exec_pkg::preg_t     rd_addr [exec_pkg::NUM_RD],
	output exec_pkg::data_t     rd_data [exec_pkg::NUM_RD],
	input  exec_pkg::wr_port_t  wr      [exec_pkg::NUM_FU]
);

	exec_pkg::data_t regs [exec_pkg::NUM_PREG];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < exec_pkg::NUM_PREG; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int w = 0; w < exec_pkg::NUM_FU; w++) begin
				if (wr[w].en) begin
					regs[wr[w].dst] <= wr[w].data;
				end
			end
		end
	end

	// same-cycle write wins over the stored value
	always_comb begin
		for (int i = 0; i < exec_pkg::NUM_RD; i++) begin
			rd_data[i] = regs[rd_addr[i]];
			for (int w = 0; w < exec_pkg::NUM_FU; w++) begin
				if (wr[w].en && (wr[w].dst == rd_addr[i])) begin
					rd_data[i] = wr[w].data;
				end
			end
		end
	end

	// renaming upstream must never hand out one preg twice in flight
	for (genvar i = 0; i < exec_pkg::NUM_FU; i++) begin : g_wr_a
		for (genvar j = i + 1; j < exec_pkg::NUM_FU; j++) begin : g_wr_b
			a_wr_unique : assert property (
				@(posedge clk) disable iff (rst)
				!(wr[i].en && wr[j].en && (wr[i].dst == wr[j].dst))
			) else $error("write ports %0d and %0d hit preg %0d together",
				i, j, wr[i].dst);
		end
	end

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

	// datapath widths
	localparam int DATA_W = 16;
	localparam int PREG_W = 6;
	localparam int NUM_PREG = 1 << PREG_W;
	localparam int ROB_W = 6;

	// one mult, two alus, one address adder
	localparam int NUM_FU = 4;
	// two source reads per unit
	localparam int NUM_RD = 2 * NUM_FU;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [ROB_W-1:0]  rob_idx_t;
	typedef logic [2:0]        alu_mode_t;

	localparam alu_mode_t ALU_ADD  = 3'd0;
	localparam alu_mode_t ALU_SUB  = 3'd1;
	localparam alu_mode_t ALU_AND  = 3'd2;
	localparam alu_mode_t ALU_OR   = 3'd3;
	localparam alu_mode_t ALU_XOR  = 3'd4;
	localparam alu_mode_t ALU_SLL  = 3'd5;
	localparam alu_mode_t ALU_SRL  = 3'd6;
	localparam alu_mode_t ALU_PASS = 3'd7;

	// unit order in packet and done arrays
	localparam int FU_MULT = 0;
	localparam int FU_ALU1 = 1;
	localparam int FU_ALU2 = 2;
	localparam int FU_ADDR = 3;

	// from the issue queue, 48 bits
	typedef struct packed {
		logic      valid;
		rob_idx_t  rob;
		preg_t     dst;
		logic      reg_wrt;
		preg_t     src1;
		preg_t     src2;
		data_t     imm;
		logic      imm_vld;
		logic      ldi;
		logic      inv_rt;
		alu_mode_t mode;
	} iss_pkt_t;

	// op2 already replaced by imm when imm_vld, not yet inverted
	typedef struct packed {
		logic      valid;
		rob_idx_t  rob;
		preg_t     dst;
		logic      reg_wrt;
		data_t     op1;
		data_t     op2;
		data_t     imm;
		logic      ldi;
		logic      inv_rt;
		alu_mode_t mode;
	} ex_pkt_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob;
		logic     reg_wrt;
		preg_t    dst;
		data_t    data;
	} done_t;

	typedef struct packed {
		logic  en;
		preg_t dst;
		data_t data;
	} wr_port_t;

endpackage
